/* tb.f */
+incdir+include
design/ps2_pkg.sv
design/abc80_key_pkg.sv
design/ps2_key_decoder.sv
design/key_repeat_timer.sv
design/abc80_keyboard.sv
verif/abc80_keyboard_assertions.sv
verif/abc80_keyboard_tb.sv

/* Makefile */
VERILATOR   = verilator
TOP         = abc80_keyboard_tb
FILELIST    = tb.f
OBJ_DIR     = obj_dir
BUILD_FLAGS = --binary --assert --timing -j 0
LINT_FLAGS  = --lint-only --assert --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* verif/abc80_keyboard_tb.sv */
// ======================================================================
// Testbench for the ABC80 keyboard path
// Scan code table, key-down pulse and auto-repeat timing checks
// ======================================================================
`timescale 1ns/100ps

module abc80_keyboard_tb
	import ps2_pkg::*, abc80_key_pkg::*;
;

	localparam int NUM_EVENTS     = 28;
	localparam int TIMEOUT_CYCLES = 2 * NUM_EVENTS * 100 + 400;

	typedef struct packed {
		logic       ext;
		logic [7:0] code;
		logic       pressed;
		logic [6:0] exp_char;
		logic       changes;    // key_char expected to move
	} kbd_event_t;

	// ext, code, pressed, expected key_char, changes
	kbd_event_t events [NUM_EVENTS] = '{
		'{1'b0, 8'h1C, 1'b1, 7'h61, 1'b1},    // a
		'{1'b0, 8'h1A, 1'b1, 7'h7A, 1'b1},    // z
		'{1'b0, 8'h12, 1'b1, 7'h7A, 1'b0},    // Left Shift down
		'{1'b0, 8'h1C, 1'b1, 7'h41, 1'b1},    // A
		'{1'b0, 8'h1A, 1'b1, 7'h5A, 1'b1},    // Z
		'{1'b0, 8'h16, 1'b1, 7'h21, 1'b1},    // Shift 1
		'{1'b0, 8'h45, 1'b1, 7'h3D, 1'b1},    // Shift 0
		'{1'b0, 8'h12, 1'b0, 7'h3D, 1'b0},    // Left Shift up
		'{1'b0, 8'h59, 1'b1, 7'h3D, 1'b0},    // Right Shift down
		'{1'b0, 8'h46, 1'b1, 7'h29, 1'b1},    // Shift 9
		'{1'b0, 8'h59, 1'b0, 7'h29, 1'b0},    // Right Shift up
		'{1'b0, 8'h16, 1'b1, 7'h31, 1'b1},    // 1
		'{1'b0, 8'h45, 1'b1, 7'h30, 1'b1},    // 0
		'{1'b0, 8'h7D, 1'b1, 7'h39, 1'b1},    // Keypad 9
		'{1'b0, 8'h69, 1'b1, 7'h31, 1'b1},    // Keypad 1
		'{1'b1, 8'h5A, 1'b1, 7'h0D, 1'b1},    // Keypad Enter
		'{1'b0, 8'h29, 1'b1, 7'h20, 1'b1},    // Space
		'{1'b1, 8'h74, 1'b1, 7'h09, 1'b1},    // Cursor right
		'{1'b1, 8'h6B, 1'b1, 7'h08, 1'b1},    // Cursor left
		'{1'b0, 8'h14, 1'b1, 7'h08, 1'b0},    // Ctrl down
		'{1'b0, 8'h1C, 1'b1, 7'h08, 1'b0},    // Ctrl A ignored
		'{1'b0, 8'h21, 1'b1, 7'h03, 1'b1},    // Ctrl C
		'{1'b0, 8'h22, 1'b1, 7'h18, 1'b1},    // Ctrl X
		'{1'b0, 8'h1A, 1'b1, 7'h18, 1'b0},    // Ctrl Z ignored
		'{1'b1, 8'h14, 1'b0, 7'h18, 1'b0},    // Right Ctrl up
		'{1'b0, 8'h77, 1'b1, 7'h18, 1'b0},    // Unmapped code
		'{1'b0, 8'h21, 1'b1, 7'h63, 1'b1},    // c
		'{1'b0, 8'h21, 1'b0, 7'h63, 1'b0}     // c released
	};

	logic        CLK12 = 1'b0;
	logic        RESET;
	logic        key_strobe;
	logic        key_pressed;
	logic        key_extended;
	ps2_code_t   key_code_in;
	abc80_char_t key_char;
	logic        key_down;
	key_port_t   key_port;

	abc80_char_t model_char;    // Character the table says the decoder holds
	int          cycle_cnt = 0;

	abc80_keyboard #(
		.FIRST_DELAY  (40),
		.REPEAT_DELAY (20),
		.PULSE_LEN    (6)
	) abc80_keyboard_inst (
		.CLK12        (CLK12),
		.RESET        (RESET),
		.key_strobe   (key_strobe),
		.key_pressed  (key_pressed),
		.key_extended (key_extended),
		.key_code_in  (key_code_in),
		.key_char     (key_char),
		.key_down     (key_down),
		.key_port     (key_port)
	);

	always #2 CLK12 = ~CLK12;    // 4 ns period

	// Run limit
	always @(posedge CLK12) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("test failed");
			$fatal(1, "run limit reached");
		end
	end

	// ==================================================================
	// Helper tasks
	// ==================================================================
	task automatic check_value(input string name, input logic [7:0] got,
	                           input logic [7:0] exp);
		assert (got === exp) else begin
			$display("FAILED %s: expected 0x%h, got 0x%h", name, exp, got);
			$display("test failed");
			$fatal(1, "%s mismatch", name);
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge CLK12);
			#1;
		end
	endtask

	task automatic apply_reset();
		RESET = 1'b1;
		repeat (3) @(posedge CLK12);
		#1;
		RESET = 1'b0;
	endtask

	// One strobe cycle that returns 1 ns after its sampling edge
	task automatic apply_event(input logic ext, input logic [7:0] code, input logic pressed);
		key_strobe   = 1'b1;
		key_extended = ext;
		key_code_in  = code;
		key_pressed  = pressed;
		@(posedge CLK12);
		#1;
		key_strobe = 1'b0;
	endtask

	task automatic expect_down(input logic level, input int cycles);
		repeat (cycles) begin
			@(posedge CLK12);
			#1;
			check_value("key_down", {7'd0, key_down}, {7'd0, level});
		end
	endtask

	// ==================================================================
	// Main sequence
	// ==================================================================
	initial begin
		RESET        = 1'b1;
		key_strobe   = 1'b0;
		key_pressed  = 1'b0;
		key_extended = 1'b0;
		key_code_in  = '0;
		model_char   = '0;
		void'($urandom(32'hb6d2dddb));

		apply_reset();
		check_value("key_down", {7'd0, key_down}, 8'h00);
		check_value("key_port", key_port, 8'h00);

		// Translation table with random idle gaps
		for (int i = 0; i < NUM_EVENTS; i++) begin
			idle_cycles(int'($urandom % 8));
			apply_event(events[i].ext, events[i].code, events[i].pressed);
			if (events[i].changes)
				model_char = events[i].exp_char;
			check_value("key_char", {1'b0, key_char}, {1'b0, model_char});
		end

		apply_reset();
		check_value("key_down", {7'd0, key_down}, 8'h00);
		check_value("key_port", key_port, 8'h00);

		// Held a gives a 7 cycle pulse then repeats at 41 and 21 cycles
		apply_event(1'b0, 8'h1C, 1'b1);
		check_value("key_char", {1'b0, key_char}, 8'h61);
		check_value("key_down", {7'd0, key_down}, 8'h00);
		expect_down(1'b1, 1);
		check_value("key_port", key_port, 8'h80 + 8'h61);
		expect_down(1'b1, 6);
		expect_down(1'b0, 34);
		expect_down(1'b1, 7);
		expect_down(1'b0, 14);
		expect_down(1'b1, 2);

		// Release in the middle of the third pulse
		apply_event(1'b0, 8'h1C, 1'b0);
		check_value("key_down", {7'd0, key_down}, 8'h01);
		expect_down(1'b1, 4);
		expect_down(1'b0, 40);
		check_value("key_port", key_port, 8'h61);

		$display("test passed");
		$finish;
	end

endmodule

/* verif/abc80_keyboard_assertions.sv */
// ======================================================================
// Concurrent checks on the key-down pulse of the repeat timer
// ======================================================================
`timescale 1ns/100ps

module abc80_keyboard_assertions #(
	parameter int unsigned PULSE_LEN = 6
) (
	input logic clk12,
	input logic reset,
	input logic key_held,
	input logic key_down
);

	int unsigned high_cnt;    // Consecutive cycles with key_down high

	always_ff @(posedge clk12) begin
		if (reset || !key_down)
			high_cnt <= 0;
		else
			high_cnt <= high_cnt + 1;
	end

	// Timer comes out of reset idle
	reset_clears_down: assert property (@(posedge clk12) reset |=> !key_down)
		else $error("key_down not low in the cycle after reset");

	held_before_rise: assert property (@(posedge clk12) disable iff (reset)
		$rose(key_down) |-> $past(key_held))
		else $error("key_down rose without a held key");

	pulse_length_limit: assert property (@(posedge clk12) disable iff (reset)
		high_cnt <= PULSE_LEN + 1)
		else $error("key_down stayed high longer than the pulse length");

endmodule

bind key_repeat_timer abc80_keyboard_assertions #(
	.PULSE_LEN (PULSE_LEN)
) abc80_keyboard_assertions_inst (
	.clk12    (clk12),
	.reset    (reset),
	.key_held (key_held),
	.key_down (key_down)
);

/* design/abc80_keyboard.sv */
// ======================================================================
// ABC80 keyboard top level
// Scan code decoder, repeat timer and port A byte
// ======================================================================
`timescale 1ns/100ps
`include "abc80_kbd_cfg.svh"

module abc80_keyboard
	import ps2_pkg::*, abc80_key_pkg::*;
#(
	parameter int unsigned FIRST_DELAY  = `KBD_FIRST_DELAY,
	parameter int unsigned REPEAT_DELAY = `KBD_REPEAT_DELAY,
	parameter int unsigned PULSE_LEN    = `KBD_PULSE_LEN
) (
	input  logic        CLK12,
	input  logic        RESET,
	input  logic        key_strobe,      // One cycle per PS/2 event
	input  logic        key_pressed,
	input  logic        key_extended,    // E0 prefix seen
	input  ps2_code_t   key_code_in,
	output abc80_char_t key_char,
	output logic        key_down,
	output key_port_t   key_port         // Sampled by the PIO port A
);

	logic key_held;

	ps2_key_decoder ps2_key_decoder_inst (
		.clk12        (CLK12),
		.reset        (RESET),
		.key_strobe   (key_strobe),
		.key_pressed  (key_pressed),
		.key_extended (key_extended),
		.key_code_in  (key_code_in),
		.key_held     (key_held),
		.key_char     (key_char)
	);

	key_repeat_timer #(
		.FIRST_DELAY  (FIRST_DELAY),
		.REPEAT_DELAY (REPEAT_DELAY),
		.PULSE_LEN    (PULSE_LEN)
	) key_repeat_timer_inst (
		.clk12    (CLK12),
		.reset    (RESET),
		.key_held (key_held),
		.key_down (key_down)
	);

	assign key_port = {key_down, key_char};

endmodule

/* design/key_repeat_timer.sv */
// ======================================================================
// Key-down pulse generator with initial delay and auto-repeat
// ======================================================================
`timescale 1ns/100ps
`include "abc80_kbd_cfg.svh"

module key_repeat_timer
	import abc80_key_pkg::*;
#(
	parameter int unsigned FIRST_DELAY  = `KBD_FIRST_DELAY,
	parameter int unsigned REPEAT_DELAY = `KBD_REPEAT_DELAY,
	parameter int unsigned PULSE_LEN    = `KBD_PULSE_LEN
) (
	input  logic clk12,
	input  logic reset,
	input  logic key_held,
	output logic key_down
);

	logic       key_held_d;
	logic       key_edge;
	rep_count_t pulse_cnt;
	rep_count_t rep_cnt;

	assign key_edge = key_held & ~key_held_d;    // New key pressed

	always_ff @(posedge clk12) begin
		if (reset) begin
			key_held_d <= 1'b0;
			key_down   <= 1'b0;
			pulse_cnt  <= '0;
			rep_cnt    <= '0;
		end else begin
			key_held_d <= key_held;

			// Pulse length
			if (pulse_cnt != '0)
				pulse_cnt <= pulse_cnt - rep_count_t'(1);
			else
				key_down <= 1'b0;

			// Repeat scheduling, overrides the pulse counter when a pulse starts
			if (key_edge) begin
				key_down  <= 1'b1;
				rep_cnt   <= rep_count_t'(FIRST_DELAY);
				pulse_cnt <= rep_count_t'(PULSE_LEN);
			end else if (rep_cnt != '0) begin
				rep_cnt <= rep_cnt - rep_count_t'(1);
			end else if (key_held) begin
				key_down  <= 1'b1;                       // Auto-repeat
				rep_cnt   <= rep_count_t'(REPEAT_DELAY);
				pulse_cnt <= rep_count_t'(PULSE_LEN);
			end else begin
				key_down  <= 1'b0;                       // Idle, key released
				pulse_cnt <= '0;
			end
		end
	end

endmodule

/* design/ps2_key_decoder.sv */
// ======================================================================
// PS/2 scan code decoder
// Shift and Ctrl tracking, translation to ABC80 character codes
// ======================================================================
`timescale 1ns/100ps

module ps2_key_decoder
	import ps2_pkg::*, abc80_key_pkg::*;
(
	input  logic        clk12,
	input  logic        reset,
	input  logic        key_strobe,
	input  logic        key_pressed,
	input  logic        key_extended,
	input  ps2_code_t   key_code_in,
	output logic        key_held,
	output abc80_char_t key_char
);

	logic        shift;
	logic        ctrl;
	ps2_key_t    ev_key;
	logic        is_shift;
	logic        is_ctrl;
	logic        hit;
	abc80_char_t chr;
	abc80_char_t lower_bit;

	assign ev_key    = {key_extended, key_code_in};
	assign is_shift  = (ev_key == PS2_LSHIFT) || (ev_key == PS2_RSHIFT);
	assign is_ctrl   = (key_code_in == PS2_CTRL[7:0]);    // Either side
	assign lower_bit = {1'b0, ~shift, 5'd0};              // Lower case without Shift

	// ==================================================================
	// Translation table
	// ==================================================================
	always_comb begin
		hit = 1'b1;
		chr = '0;
		casez ({ctrl, shift, ev_key})
			// Letters, Ctrl must be up
			{2'b0?, 9'h01C}: chr = 7'h41 | lower_bit;    // A
			{2'b0?, 9'h032}: chr = 7'h42 | lower_bit;    // B
			{2'b0?, 9'h021}: chr = 7'h43 | lower_bit;    // C
			{2'b0?, 9'h023}: chr = 7'h44 | lower_bit;    // D
			{2'b0?, 9'h024}: chr = 7'h45 | lower_bit;    // E
			{2'b0?, 9'h02B}: chr = 7'h46 | lower_bit;    // F
			{2'b0?, 9'h034}: chr = 7'h47 | lower_bit;    // G
			{2'b0?, 9'h033}: chr = 7'h48 | lower_bit;    // H
			{2'b0?, 9'h043}: chr = 7'h49 | lower_bit;    // I
			{2'b0?, 9'h03B}: chr = 7'h4A | lower_bit;    // J
			{2'b0?, 9'h042}: chr = 7'h4B | lower_bit;    // K
			{2'b0?, 9'h04B}: chr = 7'h4C | lower_bit;    // L
			{2'b0?, 9'h03A}: chr = 7'h4D | lower_bit;    // M
			{2'b0?, 9'h031}: chr = 7'h4E | lower_bit;    // N
			{2'b0?, 9'h044}: chr = 7'h4F | lower_bit;    // O
			{2'b0?, 9'h04D}: chr = 7'h50 | lower_bit;    // P
			{2'b0?, 9'h015}: chr = 7'h51 | lower_bit;    // Q
			{2'b0?, 9'h02D}: chr = 7'h52 | lower_bit;    // R
			{2'b0?, 9'h01B}: chr = 7'h53 | lower_bit;    // S
			{2'b0?, 9'h02C}: chr = 7'h54 | lower_bit;    // T
			{2'b0?, 9'h03C}: chr = 7'h55 | lower_bit;    // U
			{2'b0?, 9'h02A}: chr = 7'h56 | lower_bit;    // V
			{2'b0?, 9'h01D}: chr = 7'h57 | lower_bit;    // W
			{2'b0?, 9'h022}: chr = 7'h58 | lower_bit;    // X
			{2'b0?, 9'h035}: chr = 7'h59 | lower_bit;    // Y
			{2'b0?, 9'h01A}: chr = 7'h5A | lower_bit;    // Z

			// Main row digits
			{2'b00, 9'h016}: chr = 7'h31;
			{2'b00, 9'h01E}: chr = 7'h32;
			{2'b00, 9'h026}: chr = 7'h33;
			{2'b00, 9'h025}: chr = 7'h34;
			{2'b00, 9'h02E}: chr = 7'h35;
			{2'b00, 9'h036}: chr = 7'h36;
			{2'b00, 9'h03D}: chr = 7'h37;
			{2'b00, 9'h03E}: chr = 7'h38;
			{2'b00, 9'h046}: chr = 7'h39;
			{2'b00, 9'h045}: chr = 7'h30;

			// Keypad digits
			{2'b00, 9'h069}: chr = 7'h31;
			{2'b00, 9'h072}: chr = 7'h32;
			{2'b00, 9'h07A}: chr = 7'h33;
			{2'b00, 9'h06B}: chr = 7'h34;
			{2'b00, 9'h073}: chr = 7'h35;
			{2'b00, 9'h074}: chr = 7'h36;
			{2'b00, 9'h06C}: chr = 7'h37;
			{2'b00, 9'h075}: chr = 7'h38;
			{2'b00, 9'h07D}: chr = 7'h39;
			{2'b00, 9'h070}: chr = 7'h30;

			// Shifted digits, Swedish layout
			{2'b01, 9'h016}: chr = 7'h21;    // !
			{2'b01, 9'h01E}: chr = 7'h22;    // "
			{2'b01, 9'h026}: chr = 7'h23;    // #
			{2'b01, 9'h025}: chr = 7'h24;
			{2'b01, 9'h02E}: chr = 7'h25;
			{2'b01, 9'h036}: chr = 7'h26;    // &
			{2'b01, 9'h03D}: chr = 7'h27;
			{2'b01, 9'h03E}: chr = 7'h28;
			{2'b01, 9'h046}: chr = 7'h29;
			{2'b01, 9'h045}: chr = 7'h3D;    // =

			// Editing keys
			{2'b00, 9'h?5A}: chr = 7'h0D;    // Enter, main or keypad
			{2'b00, 9'h029}: chr = 7'h20;    // Space
			{2'b00, 9'h066}: chr = 7'h08;    // Backspace
			{2'b00, 9'h16B}: chr = 7'h08;    // Cursor left
			{2'b00, 9'h174}: chr = 7'h09;    // Cursor right
			{2'b10, 9'h021}: chr = 7'h03;    // Ctrl+C, break
			{2'b10, 9'h022}: chr = 7'h18;    // Ctrl+X

			// Punctuation, unshifted
			{2'b00, 9'h041}: chr = 7'h2C;    // ,
			{2'b00, 9'h049}: chr = 7'h2E;    // .
			{2'b00, 9'h04A}: chr = 7'h2D;    // -
			{2'b00, 9'h04E}: chr = 7'h2B;    // +
			{2'b00, 9'h055}: chr = 7'h60;    // Key left of Backspace
			{2'b00, 9'h054}: chr = 7'h7D;    // Key right of P
			{2'b00, 9'h05B}: chr = 7'h7E;
			{2'b00, 9'h04C}: chr = 7'h7C;    // Key right of L
			{2'b00, 9'h052}: chr = 7'h7B;
			{2'b00, 9'h05D}: chr = 7'h27;
			{2'b00, 9'h00E}: chr = 7'h3C;    // Key left of 1

			// Punctuation, shifted
			{2'b01, 9'h041}: chr = 7'h3B;
			{2'b01, 9'h049}: chr = 7'h3A;
			{2'b01, 9'h04A}: chr = 7'h5F;
			{2'b01, 9'h04E}: chr = 7'h3F;
			{2'b01, 9'h055}: chr = 7'h40;
			{2'b01, 9'h054}: chr = 7'h5D;
			{2'b01, 9'h05B}: chr = 7'h5E;
			{2'b01, 9'h04C}: chr = 7'h5C;
			{2'b01, 9'h052}: chr = 7'h5B;
			{2'b01, 9'h05D}: chr = 7'h2A;
			{2'b01, 9'h00E}: chr = 7'h3E;
			{2'b1?, 9'h00E}: chr = 7'h7F;    // Ctrl, delete

			default:         hit = 1'b0;     // Unknown key, ignored
		endcase
	end

	// ==================================================================
	// Modifier and key state
	// ==================================================================
	always_ff @(posedge clk12) begin
		if (reset) begin
			shift    <= 1'b0;
			ctrl     <= 1'b0;
			key_held <= 1'b0;
			key_char <= '0;
		end else if (key_strobe) begin
			if (is_shift)
				shift <= key_pressed;
			else if (is_ctrl)
				ctrl <= key_pressed;
			else if (hit) begin
				key_held <= key_pressed;    // Release of the same key drops it
				key_char <= chr;
			end
		end
	end

endmodule

/* design/abc80_key_pkg.sv */
// ======================================================================
// ABC80 keyboard side types
// Character code, parallel port byte and repeat counters
// ======================================================================
`include "abc80_kbd_cfg.svh"

package abc80_key_pkg;

	// 7-bit ABC80 character code
	typedef logic [6:0] abc80_char_t;

	// Port A byte, bit 7 key-down, bits 6..0 character
	typedef logic [7:0] key_port_t;

	// Pulse and repeat down-counters
	typedef logic [`KBD_CNT_W-1:0] rep_count_t;

endpackage

/* design/ps2_pkg.sv */
// ======================================================================
// PS/2 input side types and modifier scan codes
// ======================================================================

package ps2_pkg;

	// Raw set 2 scan code as delivered by the PS/2 receiver
	typedef logic [7:0] ps2_code_t;

	// Extended flag above the scan code, the decoder's match key
	typedef logic [8:0] ps2_key_t;

	// ==================================================================
	// Modifier keys
	// ==================================================================
	localparam ps2_key_t PS2_LSHIFT = 9'h012;    // Left Shift
	localparam ps2_key_t PS2_RSHIFT = 9'h059;    // Right Shift

	// Left Ctrl is 0x014, right Ctrl is 0x114, the decoder
	// compares only the code bits so both sides count
	localparam ps2_key_t PS2_CTRL   = 9'h014;

endpackage

/* include/abc80_kbd_cfg.svh */
// ======================================================================
// Keyboard timing configuration
// Auto-repeat delays, key-down pulse length and counter width
// ======================================================================
`ifndef ABC80_KBD_CFG_SVH
`define ABC80_KBD_CFG_SVH

// Cycles of CLK12 from the first key-down pulse to the first repeat
`define KBD_FIRST_DELAY  2_000_000

// Cycles between later repeats
`define KBD_REPEAT_DELAY 500_000

// Key-down pulse length count, pulse lasts one cycle more
`define KBD_PULSE_LEN    300_000

`define KBD_CNT_W        24        // Wide enough for the first delay

`endif
